//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -Mdir obj_dir -f files.f
	./obj_dir/VcpuCoreTb | tee $(LOG)
	@grep -q "^No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
+incdir+include
hdl/rvPkg.sv
hdl/stageRegister.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/operandForward.sv
hdl/executeUnit.sv
hdl/memoryStage.sv
hdl/cpuCore.sv
tb/cpuCoreTb.sv

//--- hdl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import rvPkg::*; #(
  parameter int dataMemWords = 128
) (
  input  logic      CLK,
  input  logic      RESET,
  output dataWord   fetchAddr,
  input  dataWord   instrWord,
  output retireInfo retire
);

  fetchBundle fetchedF;
  fetchBundle fetchedD;
  execBundle  issuedD;
  execBundle  stageE;
  memBundle   resultE;
  memBundle   stageM;
  dataWord    operandA;
  dataWord    operandB;
  logic       loadUseStall;

  // ====================================================================
  // fetch and decode
  // ====================================================================

  fetchStage fetch0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .stall     (loadUseStall),
    .fetchAddr (fetchAddr),
    .instrWord (instrWord),
    .fetched   (fetchedF)
  );

  stageRegister #(.payloadType(fetchBundle)) ifIdReg (
    .CLK    (CLK),
    .RESET  (RESET),
    .stall  (loadUseStall),
    .bubble (1'b0),
    .din    (fetchedF),
    .dout   (fetchedD)
  );

  decodeStage decode0 (
    .CLK          (CLK),
    .RESET        (RESET),
    .decoded      (fetchedD),
    .issued       (issuedD),
    .inExecute    (stageE),
    .loadUseStall (loadUseStall),
    .writeback    (retire)
  );

  stageRegister #(.payloadType(execBundle)) idExReg (
    .CLK    (CLK),
    .RESET  (RESET),
    .stall  (1'b0),
    .bubble (loadUseStall),
    .din    (issuedD),
    .dout   (stageE)
  );

  // ====================================================================
  // execute, memory, writeback
  // ====================================================================

  operandForward fwdA (
    .srcReg    (stageE.rs1),
    .regValue  (stageE.regValue1),
    .memStage  (stageM),
    .writeback (retire),
    .operand   (operandA)
  );

  operandForward fwdB (
    .srcReg    (stageE.rs2),
    .regValue  (stageE.regValue2),
    .memStage  (stageM),
    .writeback (retire),
    .operand   (operandB)
  );

  executeUnit execute0 (
    .stage    (stageE),
    .operandA (operandA),
    .operandB (operandB),
    .result   (resultE)
  );

  stageRegister #(.payloadType(memBundle)) exMemReg (
    .CLK    (CLK),
    .RESET  (RESET),
    .stall  (1'b0),
    .bubble (1'b0),
    .din    (resultE),
    .dout   (stageM)
  );

  memoryStage #(.dataMemWords(dataMemWords)) memory0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .stage     (stageM),
    .writeback (retire)  // also feeds regfile and forwarding
  );

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import rvPkg::*; (
  input  logic       CLK,
  input  logic       RESET,
  input  fetchBundle decoded,
  output execBundle  issued,
  input  execBundle  inExecute,
  output logic       loadUseStall,
  input  retireInfo  writeback
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  regAddr      rdField;
  regAddr      srcReg1;
  regAddr      srcReg2;
  dataWord     rdata1;
  dataWord     rdata2;
  dataWord     imm;
  logic        writesRd;
  logic        usesRs1;
  logic        usesRs2;
  logic        memWrite;
  logic        aluSrc;
  aluOp        aluCode;
  resultSource resultFrom;
  immFormat    immSel;

  function automatic aluOp aluDecode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? aluSub : aluAdd;
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b011:  return aluSltu;
      3'b100:  return aluXor;
      3'b101:  return alt ? aluSra : aluSrl;
      3'b110:  return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  // ====================================================================
  // fields and control
  // ====================================================================

  assign opcode  = decoded.instr[6:0];
  assign rdField = decoded.instr[11:7];
  assign funct3  = decoded.instr[14:12];
  assign funct7  = decoded.instr[31:25];

  always_comb begin
    writesRd   = 1'b0;  // anything unknown is a nop
    usesRs1    = 1'b0;
    usesRs2    = 1'b0;
    memWrite   = 1'b0;
    aluSrc     = 1'b0;
    aluCode    = aluAdd;
    resultFrom = fromAlu;
    immSel     = immI;
    case (opcode)
      opLoad: begin
        writesRd   = 1'b1;
        usesRs1    = 1'b1;
        aluSrc     = 1'b1;
        resultFrom = fromMemory;
      end
      opStore: begin
        usesRs1  = 1'b1;
        usesRs2  = 1'b1;
        memWrite = 1'b1;
        aluSrc   = 1'b1;
        immSel   = immS;
      end
      opAluImm: begin
        writesRd = 1'b1;
        usesRs1  = 1'b1;
        aluSrc   = 1'b1;
        // funct7 only selects srai here since addi never subtracts
        aluCode  = aluDecode(funct3, funct7[5] && funct3 == 3'b101);
      end
      opAluReg: begin
        writesRd = 1'b1;
        usesRs1  = 1'b1;
        usesRs2  = 1'b1;
        aluCode  = aluDecode(funct3, funct7[5]);
      end
      opLui: begin
        writesRd = 1'b1;  // x0 + imm through the adder
        aluSrc   = 1'b1;
        immSel   = immU;
      end
      default: ;
    endcase
  end

  // unused source fields read x0 and never forward or stall
  assign srcReg1 = usesRs1 ? decoded.instr[19:15] : '0;
  assign srcReg2 = usesRs2 ? decoded.instr[24:20] : '0;

  always_comb begin
    case (immSel)
      immS:    imm = {{20{decoded.instr[31]}}, decoded.instr[31:25], decoded.instr[11:7]};
      immU:    imm = {decoded.instr[31:12], 12'b0};
      default: imm = {{20{decoded.instr[31]}}, decoded.instr[31:20]};
    endcase
  end

  regFile regs0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .rs1       (srcReg1),
    .rs2       (srcReg2),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .writeback (writeback)
  );

  assign issued = '{
    regValue1:  rdata1,
    regValue2:  rdata2,
    imm:        imm,
    rs1:        srcReg1,
    rs2:        srcReg2,
    rd:         rdField,
    regWrite:   writesRd && (rdField != '0),
    memWrite:   memWrite,
    aluSrc:     aluSrc,
    aluCode:    aluCode,
    resultFrom: resultFrom
  };

  // load in execute whose rd we need right now
  assign loadUseStall = inExecute.regWrite && inExecute.resultFrom == fromMemory &&
                        (inExecute.rd == srcReg1 || inExecute.rd == srcReg2);

endmodule

`default_nettype wire

//--- hdl/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit import rvPkg::*; (
  input  execBundle stage,
  input  dataWord   operandA,
  input  dataWord   operandB,
  output memBundle  result
);

  dataWord    srcB;
  dataWord    aluOut;
  logic [4:0] shamt;

  assign srcB  = stage.aluSrc ? stage.imm : operandB;
  assign shamt = srcB[4:0];

  always_comb begin
    case (stage.aluCode)
      aluAdd:  aluOut = operandA + srcB;
      aluSub:  aluOut = operandA - srcB;
      aluAnd:  aluOut = operandA & srcB;
      aluOr:   aluOut = operandA | srcB;
      aluXor:  aluOut = operandA ^ srcB;
      aluSlt:  aluOut = {31'b0, $signed(operandA) < $signed(srcB)};
      aluSltu: aluOut = {31'b0, operandA < srcB};
      aluSll:  aluOut = operandA << shamt;
      aluSrl:  aluOut = operandA >> shamt;
      aluSra:  aluOut = $signed(operandA) >>> shamt;  // keeps the sign
      default: aluOut = '0;
    endcase
  end

  assign result = '{
    aluResult:  aluOut,
    storeData:  operandB,  // forwarded rs2
    rd:         stage.rd,
    regWrite:   stage.regWrite,
    memWrite:   stage.memWrite,
    resultFrom: stage.resultFrom
  };

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage import rvPkg::*; (
  input  logic       CLK,
  input  logic       RESET,
  input  logic       stall,
  output dataWord    fetchAddr,
  input  dataWord    instrWord,
  output fetchBundle fetched
);

  dataWord pc;
  dataWord pcPlus4;

  assign pcPlus4 = pc + 32'd4;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pcPlus4;  // always sequential without branches
    end
  end

  assign fetchAddr = pc;
  assign fetched   = '{instr: instrWord, pc: pc};

  pcWordAligned: assert property (
    @(posedge CLK) disable iff (RESET) fetchAddr[1:0] == 2'b00
  );

endmodule

`default_nettype wire

//--- hdl/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage import rvPkg::*; #(
  parameter int dataMemWords = 128
) (
  input  logic      CLK,
  input  logic      RESET,
  input  memBundle  stage,
  output retireInfo writeback
);

  localparam int indexBits = $clog2(dataMemWords);

  dataWord              ram [dataMemWords];
  logic [indexBits-1:0] wordIndex;
  dataWord              readData;
  dataWord              wbAluResult;
  regAddr               wbRd;
  logic                 wbValid;
  resultSource          wbFrom;

  assign wordIndex = stage.aluResult[indexBits+1:2];  // word addressed

  // read every cycle so data arrives with the MEM/WB register
  always_ff @(posedge CLK) begin
    if (stage.memWrite) begin
      ram[wordIndex] <= stage.storeData;
    end
    readData <= ram[wordIndex];
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      wbValid <= 1'b0;
      wbFrom  <= fromAlu;
    end else begin
      wbValid <= stage.regWrite;
      wbFrom  <= stage.resultFrom;
    end
  end

  always_ff @(posedge CLK) begin
    wbRd        <= stage.rd;
    wbAluResult <= stage.aluResult;
  end

  assign writeback = '{
    valid: wbValid,
    rd:    wbRd,
    value: (wbFrom == fromMemory) ? readData : wbAluResult
  };

  // address from execute must land inside the RAM
  accessInRange: assert property (
    @(posedge CLK) disable iff (RESET)
    (stage.memWrite || stage.resultFrom == fromMemory) |-> stage.aluResult[31:2] < dataMemWords
  );

endmodule

`default_nettype wire

//--- hdl/operandForward.sv
`timescale 1ns/1ps
`default_nettype none

module operandForward import rvPkg::*; (
  input  regAddr    srcReg,
  input  dataWord   regValue,
  input  memBundle  memStage,
  input  retireInfo writeback,
  output dataWord   operand
);

  logic memHit;
  logic wbHit;

  // x0 is never a forwarding target
  assign memHit = (srcReg != '0) && memStage.regWrite && (memStage.rd == srcReg);
  assign wbHit  = (srcReg != '0) && writeback.valid && (writeback.rd == srcReg);

  // newest value wins
  always_comb begin
    if (memHit) begin
      operand = memStage.aluResult;  // never a load because of the load-use stall
    end else if (wbHit) begin
      operand = writeback.value;
    end else begin
      operand = regValue;
    end
  end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
  input  logic      CLK,
  input  logic      RESET,
  input  regAddr    rs1,
  input  regAddr    rs2,
  output dataWord   rdata1,
  output dataWord   rdata2,
  input  retireInfo writeback
);

  dataWord regs [32];

  // x0 reads zero and a same-cycle write passes straight through
  function automatic dataWord readPort(input regAddr addr);
    if (addr == '0) begin
      return '0;
    end else if (writeback.valid && writeback.rd == addr) begin
      return writeback.value;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge CLK) begin
    if (RESET) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeback.valid && writeback.rd != '0) begin
      regs[writeback.rd] <= writeback.value;
    end
  end

  always_comb begin
    rdata1 = readPort(rs1);
    rdata2 = readPort(rs2);
  end

endmodule

`default_nettype wire

//--- hdl/rvPkg.sv
`default_nettype none

package rvPkg;

  // ====================================================================
  // basic types and opcodes
  // ====================================================================

  typedef logic [31:0] dataWord;  // data, addresses, instructions
  typedef logic [4:0]  regAddr;

  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opAluImm = 7'b0010011;
  localparam logic [6:0] opAluReg = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;

  // top two bits pick the ALU group
  typedef enum logic [3:0] {
    aluAdd  = 4'b0000,
    aluSub  = 4'b0001,
    aluAnd  = 4'b0100,
    aluOr   = 4'b0101,
    aluXor  = 4'b0110,
    aluSlt  = 4'b1000,
    aluSltu = 4'b1001,
    aluSrl  = 4'b1101,
    aluSll  = 4'b1110,
    aluSra  = 4'b1111
  } aluOp;

  typedef enum logic {fromAlu = 1'b0, fromMemory = 1'b1} resultSource;

  typedef enum logic [1:0] {immI, immS, immU} immFormat;

  // ====================================================================
  // stage bundles
  // ====================================================================

  typedef struct packed {
    dataWord     instr;
    dataWord     pc;
  } fetchBundle;

  typedef struct packed {
    dataWord     regValue1;
    dataWord     regValue2;
    dataWord     imm;
    regAddr      rs1;         // zero when the field is not a source
    regAddr      rs2;
    regAddr      rd;
    logic        regWrite;    // only set for nonzero rd
    logic        memWrite;
    logic        aluSrc;      // second operand is the immediate
    aluOp        aluCode;
    resultSource resultFrom;
  } execBundle;

  typedef struct packed {
    dataWord     aluResult;   // also the load/store address
    dataWord     storeData;
    regAddr      rd;
    logic        regWrite;
    logic        memWrite;
    resultSource resultFrom;
  } memBundle;

  typedef struct packed {
    logic        valid;
    regAddr      rd;
    dataWord     value;
  } retireInfo;

endpackage

`default_nettype wire

//--- hdl/stageRegister.sv
`timescale 1ns/1ps
`default_nettype none

module stageRegister #(
  parameter type payloadType = logic [31:0]
) (
  input  logic       CLK,
  input  logic       RESET,
  input  logic       stall,   // hold current contents
  input  logic       bubble,  // load an all-zero payload
  input  payloadType din,
  output payloadType dout
);

  always_ff @(posedge CLK) begin
    if (RESET || bubble) begin
      dout <= '0;  // zero payload decodes as a no-op
    end else if (!stall) begin
      dout <= din;
    end
  end

  // a held stage must never be squashed in the same cycle
  stallBubbleExclusive: assert property (
    @(posedge CLK) disable iff (RESET) !(stall && bubble)
  );

endmodule

`default_nettype wire

//--- include/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// ======================================================================
// instruction encoders
// ======================================================================

function automatic rvPkg::dataWord encR(input logic [6:0] funct7, input rvPkg::regAddr rs2,
    input rvPkg::regAddr rs1, input logic [2:0] funct3, input rvPkg::regAddr rd);
  return {funct7, rs2, rs1, funct3, rd, rvPkg::opAluReg};
endfunction

function automatic rvPkg::dataWord encI(input logic [11:0] imm, input rvPkg::regAddr rs1,
    input logic [2:0] funct3, input rvPkg::regAddr rd);
  return {imm, rs1, funct3, rd, rvPkg::opAluImm};
endfunction

function automatic rvPkg::dataWord encLw(input logic [11:0] imm, input rvPkg::regAddr rs1,
    input rvPkg::regAddr rd);
  return {imm, rs1, 3'b010, rd, rvPkg::opLoad};
endfunction

function automatic rvPkg::dataWord encSw(input logic [11:0] imm, input rvPkg::regAddr rs2,
    input rvPkg::regAddr rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
endfunction

function automatic rvPkg::dataWord encLui(input logic [19:0] imm, input rvPkg::regAddr rd);
  return {imm, rd, rvPkg::opLui};
endfunction

// ======================================================================
// in-order reference
// ======================================================================

function automatic rvPkg::dataWord isaAlu(input logic [2:0] funct3, input logic alt,
    input rvPkg::dataWord a, input rvPkg::dataWord b);
  logic [4:0] shamt;
  shamt = b[4:0];
  case (funct3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << shamt;
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101: begin
      if (alt) begin
        return $signed(a) >>> shamt;
      end
      return a >> shamt;
    end
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// runs the program once, top to bottom, and lists the expected retires
function automatic void isaRun(input rvPkg::dataWord prog [$],
    output rvPkg::retireInfo expected [$]);
  rvPkg::dataWord regs [32];
  rvPkg::dataWord mem [int unsigned];
  rvPkg::dataWord a;
  rvPkg::dataWord b;
  rvPkg::dataWord immI;
  rvPkg::dataWord immS;
  rvPkg::dataWord value;
  rvPkg::regAddr  rd;
  logic [2:0]     f3;
  logic           writes;
  int unsigned    idx;
  expected = {};
  foreach (regs[i]) begin
    regs[i] = '0;
  end
  foreach (prog[k]) begin
    rd     = prog[k][11:7];
    f3     = prog[k][14:12];
    a      = regs[prog[k][19:15]];
    b      = regs[prog[k][24:20]];
    immI   = {{20{prog[k][31]}}, prog[k][31:20]};
    immS   = {{20{prog[k][31]}}, prog[k][31:25], prog[k][11:7]};
    writes = 1'b1;
    value  = '0;
    case (prog[k][6:0])
      rvPkg::opAluReg: value = isaAlu(f3, prog[k][30], a, b);
      rvPkg::opAluImm: value = isaAlu(f3, prog[k][30] && f3 == 3'b101, a, immI);
      rvPkg::opLui:    value = {prog[k][31:12], 12'b0};
      rvPkg::opLoad: begin
        idx   = (a + immI) >> 2;
        value = mem.exists(idx) ? mem[idx] : '0;  // unwritten words read zero
      end
      rvPkg::opStore: begin
        idx      = (a + immS) >> 2;
        mem[idx] = b;
        writes   = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    if (writes && rd != '0) begin
      regs[rd] = value;
      expected.push_back('{valid: 1'b1, rd: rd, value: value});
    end
  end
endfunction

`endif

//--- tb/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb import rvPkg::*; ();

  localparam int      memWords = 128;
  localparam dataWord nop      = 32'h0000_0013;  // addi x0, x0, 0

  logic      CLK;
  logic      RESET;
  dataWord   fetchAddr;
  dataWord   instrWord;
  retireInfo retire;

  dataWord   progQ [$];
  retireInfo expQ [$];
  string     testName;
  logic      checking;  // comparator armed
  int        retIdx;
  int        testErrors;
  int        errorCount;
  int        testCount;
  int        failedTests;
  int        beatCount;

  `include "isaModel.svh"

  cpuCore #(.dataMemWords(memWords)) dut0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .fetchAddr (fetchAddr),
    .instrWord (instrWord),
    .retire    (retire)
  );

  always #2 CLK = ~CLK;

  // ====================================================================
  // fetch server and retire comparator
  // ====================================================================

  function automatic dataWord fetchWord(input dataWord addr);
    int unsigned idx;
    idx = addr >> 2;
    if (idx < progQ.size()) begin
      return progQ[idx];
    end
    return nop;  // past the end of the program
  endfunction

  always @(negedge CLK) begin
    instrWord <= fetchWord(fetchAddr);
  end

  always @(negedge CLK) begin
    if (checking && retire.valid) begin
      if (retIdx >= expQ.size()) begin
        $display("%s: unexpected retire of x%0d after the last expected result",
                 testName, retire.rd);
        testErrors++;
      end else if (retire.rd !== expQ[retIdx].rd || retire.value !== expQ[retIdx].value) begin
        $display("[ERROR] %s: retire %0d expected x%0d=%08h, actual x%0d=%08h", testName,
                 retIdx, expQ[retIdx].rd, expQ[retIdx].value, retire.rd, retire.value);
        testErrors++;
      end
      retIdx++;
    end
  end

  // ====================================================================
  // program helpers
  // ====================================================================

  task automatic emit(input dataWord w);
    progQ.push_back(w);
  endtask

  // lui + addi with the upper part rounded for the signed low half
  task automatic emitConst(input regAddr rd, input dataWord v);
    dataWord upper;
    upper = v + 32'h800;
    emit(encLui(upper[31:12], rd));
    emit(encI(v[11:0], rd, 3'b000, rd));
  endtask

  function automatic logic [11:0] aluImm(input logic [2:0] f3, input logic alt);
    if (f3 == 3'b001) begin
      return {7'b0, 5'($urandom)};
    end else if (f3 == 3'b101) begin
      return {alt ? 7'b0100000 : 7'b0, 5'($urandom)};
    end
    return 12'($urandom);
  endfunction

  function automatic logic [6:0] aluFunct7(input logic [2:0] f3, input logic alt);
    return (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
  endfunction

  function automatic regAddr randReg(input int lo, input int hi);
    return regAddr'(lo + $urandom % (hi - lo + 1));
  endfunction

  // ====================================================================
  // test programs
  // ====================================================================

  task automatic buildResetProg();
    emitConst(5'd1, 32'h1234_5678);
    emit(encI(12'h001, 5'd1, 3'b000, 5'd2));
  endtask

  task automatic buildAluProg();
    dataWord    v;
    logic [2:0] f3;
    logic       alt;
    for (int r = 1; r <= 8; r++) begin
      v = $urandom();
      if (r == 1) begin
        v[31] = 1'b1;  // negative operand
      end
      if (r == 2) begin
        v[31] = 1'b0;
      end
      emitConst(regAddr'(r), v);
    end
    for (int f = 0; f < 8; f++) begin
      emit(encR(7'b0, 5'd2, 5'd1, 3'(f), regAddr'(9 + f)));
      emit(encI(aluImm(3'(f), 1'b0), 5'd1, 3'(f), regAddr'(17 + f)));
    end
    emit(encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd25));  // sub
    emit(encR(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd26));  // sra of a negative word
    emit(encI(12'h407, 5'd1, 3'b101, 5'd27));           // srai by 7
    emit(encR(7'b0, 5'd1, 5'd2, 3'b010, 5'd28));        // signed and unsigned disagree
    emit(encR(7'b0, 5'd1, 5'd2, 3'b011, 5'd29));
    repeat (30) begin
      f3  = 3'($urandom);
      alt = 1'($urandom);
      if ($urandom % 2 == 0) begin
        emit(encR(aluFunct7(f3, alt), randReg(1, 31), randReg(1, 31), f3, randReg(9, 31)));
      end else begin
        emit(encI(aluImm(f3, alt), randReg(1, 31), f3, randReg(9, 31)));
      end
    end
  endtask

  task automatic buildForwardProg();
    regAddr prev;
    regAddr rd;
    emitConst(5'd1, $urandom());
    for (int d = 1; d <= 3; d++) begin
      prev = 5'd1;
      for (int i = 0; i < 5; i++) begin
        rd = regAddr'(d * 6 + i);
        if (i == 4) begin
          emit(encR(7'b0, prev, prev, 3'b000, rd));  // both operands forwarded
        end else if (i % 2 == 0) begin
          emit(encI(12'($urandom), prev, 3'b000, rd));
        end else begin
          emit(encR(7'b0, prev, 5'd1, 3'b000, rd));
        end
        for (int j = 1; j < d; j++) begin
          emit(encI(12'(j), 5'd0, 3'b000, regAddr'(26 + j)));  // unrelated filler
        end
        prev = rd;
      end
    end
    // memory stage result must win over writeback
    emit(encI(12'h003, 5'd0, 3'b000, 5'd23));
    emit(encI(12'h005, 5'd23, 3'b000, 5'd23));
    emit(encI(12'h009, 5'd23, 3'b000, 5'd23));
    emit(encR(7'b0, 5'd23, 5'd23, 3'b000, 5'd24));
  endtask

  task automatic buildLoadUseProg();
    emitConst(5'd2, 32'h0000_0040);
    emitConst(5'd3, $urandom());
    emitConst(5'd4, $urandom());
    emit(encSw(12'h000, 5'd3, 5'd2));
    emit(encSw(12'h004, 5'd4, 5'd2));
    emit(encLw(12'h000, 5'd2, 5'd5));
    emit(encR(7'b0, 5'd3, 5'd5, 3'b000, 5'd6));  // rs1 right after the load
    emit(encLw(12'h004, 5'd2, 5'd7));
    emit(encR(7'b0, 5'd7, 5'd3, 3'b110, 5'd8));  // rs2 right after the load
    emit(encLw(12'h000, 5'd2, 5'd9));
    emit(encSw(12'h008, 5'd9, 5'd2));            // store data from the load
    emit(encLw(12'h008, 5'd2, 5'd10));
    emit(encI(12'h001, 5'd10, 3'b000, 5'd11));
    emit(encLw(12'h004, 5'd2, 5'd12));
    emit(encLw(12'h000, 5'd2, 5'd13));
    emit(encR(7'b0, 5'd13, 5'd12, 3'b000, 5'd14));
  endtask

  task automatic buildMemoryProg();
    int unsigned idx [10];
    for (int i = 0; i < 10; i++) begin
      idx[i] = $urandom % memWords;
      emitConst(5'd3, $urandom());
      emit(encSw(12'(idx[i] * 4), 5'd3, 5'd0));
    end
    emitConst(5'd3, $urandom());
    emit(encSw(12'(idx[0] * 4), 5'd3, 5'd0));  // overwrite the first word
    for (int i = 0; i < 10; i++) begin
      emit(encLw(12'(idx[i] * 4), 5'd0, regAddr'(10 + i)));
    end
  endtask

  task automatic buildZeroProg();
    emitConst(5'd1, $urandom());
    emitConst(5'd2, $urandom());
    emit(encI(12'h005, 5'd0, 3'b000, 5'd0));
    emit(encR(7'b0, 5'd2, 5'd1, 3'b000, 5'd0));
    emit(encR(7'b0, 5'd0, 5'd0, 3'b000, 5'd5));  // must not see the x0 writes
    emit(encLui(20'h12345, 5'd0));
    emit(encI(12'h000, 5'd0, 3'b110, 5'd6));
    emit(encSw(12'h020, 5'd1, 5'd0));
    emit(encLw(12'h020, 5'd0, 5'd0));
    emit(encR(7'b0, 5'd0, 5'd1, 3'b110, 5'd7));
    emit(32'h0020_8463);                         // beq is not kept and decodes as a nop
    emit(encI(12'h007, 5'd0, 3'b000, 5'd8));
  endtask

  // ====================================================================
  // sequencing
  // ====================================================================

  task automatic enterReset();
    @(posedge CLK);
    checking = 1'b0;
    @(negedge CLK);
    RESET = 1'b1;
    @(posedge CLK);
    progQ = {};
  endtask

  task automatic runTest(input string name);
    int cycles;
    int limit;
    testName   = name;
    testErrors = 0;
    retIdx     = 0;
    isaRun(progQ, expQ);
    repeat (10) begin
      @(negedge CLK);
      if (fetchAddr !== '0 || retire.valid !== 1'b0) begin
        $display("[ERROR] %s: in reset expected fetchAddr=00000000 valid=0, actual %08h %0b",
                 name, fetchAddr, retire.valid);
        testErrors++;
      end
    end
    RESET = 1'b0;
    #1;
    if (fetchAddr !== '0 || retire.valid !== 1'b0) begin
      $display("[ERROR] %s: after reset expected fetchAddr=00000000 valid=0, actual %08h %0b",
               name, fetchAddr, retire.valid);
      testErrors++;
    end
    checking = 1'b1;
    cycles   = 0;
    limit    = 4 * progQ.size() + 50;
    while (retIdx < expQ.size() && cycles <= limit) begin
      @(posedge CLK);
      cycles++;
    end
    if (retIdx < expQ.size()) begin
      $display("%s: timed out after %0d cycles with %0d of %0d results retired",
               name, cycles, retIdx, expQ.size());
      $display("Errors found");
      $finish;
    end
    repeat (8) @(posedge CLK);  // catch stray beats
    checking = 1'b0;
    $display("test %s: %0d results checked, %0d mismatches", name, expQ.size(), testErrors);
    testCount++;
    beatCount  += expQ.size();
    errorCount += testErrors;
    if (testErrors != 0) begin
      failedTests++;
    end
  endtask

  initial begin
    CLK         = 1'b0;
    RESET       = 1'b1;
    instrWord   = nop;
    checking    = 1'b0;
    retIdx      = 0;
    testErrors  = 0;
    errorCount  = 0;
    testCount   = 0;
    failedTests = 0;
    beatCount   = 0;
    void'($urandom(32'he6fe610e));

    enterReset();
    buildResetProg();
    runTest("reset");
    enterReset();
    buildAluProg();
    runTest("alu");
    enterReset();
    buildForwardProg();
    runTest("forward");
    enterReset();
    buildLoadUseProg();
    runTest("loaduse");
    enterReset();
    buildMemoryProg();
    runTest("memory");
    enterReset();
    buildZeroProg();
    runTest("x0");

    $display("%0d tests, %0d failed, %0d results checked, %0d errors",
             testCount, failedTests, beatCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
